/* hdl/addr_predecode.sv */
// address predecoder for one port
// all word selects fall false while en is low or reset is high,
// since the bit-0 group is qualified by both
`default_nettype none

module addr_predecode (
  input  wire logic           reset,
  input  wire logic           en,
  input  regfile_pkg::rf_adr_t adr,
  output regfile_pkg::predec_t sel
);

  import regfile_pkg::*;

  // array enable, no external strobe
  logic arr_en;
  logic act;

  assign arr_en = ~reset;
  assign act    = en & arr_en;

  always_comb begin
    sel = '0;
    // qualified bit-0 group
    sel.c_a0[0] = act & ~adr[0];
    sel.c_a0[1] = act & adr[0];
    // remaining groups are plain one-hot
    sel.a12 = 4'(1) << adr[2:1];
    sel.a3  = 2'(1) << adr[3];
    sel.a45 = 4'(1) << adr[5:4];
  end

endmodule

`default_nettype wire

/* hdl/port_latch.sv */
// input register for one port request
// clears to zero under reset, so the request enable is inactive
`default_nettype none

module port_latch #(
  parameter type payload_t = regfile_pkg::rd_req_t
) (
  input  wire logic clk,
  input  wire logic reset,
  input  payload_t  d,
  output payload_t  q
);

  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* hdl/read_data_stage.sv */
// read-data output stage
// latch_rd = 1 registers the read words and clears them under reset
// latch_rd = 0 passes the array output straight through
`default_nettype none

`include "regfile_defines.svh"

module read_data_stage #(
  parameter bit latch_rd = 1'b1
) (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  regfile_pkg::rf_word_t [`RF_RD_PORTS-1:0]  raw,
  output regfile_pkg::rf_word_t [`RF_RD_PORTS-1:0]  rd_dat
);

  if (latch_rd) begin : g_latched
    always_ff @(posedge clk) begin
      if (reset) begin
        rd_dat <= '0;
      end else begin
        rd_dat <= raw;
      end
    end
  end else begin : g_direct
    // clk and reset only matter when latched
    assign rd_dat = raw;
  end

endmodule

`default_nettype wire

/* hdl/regfile_4r2w.sv */
// 64 x 72 register file, four read ports and two write ports
// every request is registered at the input; no back-pressure
// read latency is 2 cycles with latch_rd = 1, 1 cycle otherwise
// array contents are not cleared by reset
`default_nettype none

`include "regfile_defines.svh"

module regfile_4r2w #(
  parameter bit latch_rd = 1'b1
) (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  regfile_pkg::rd_req_t  [`RF_RD_PORTS-1:0]  rd_req,
  input  regfile_pkg::wr_req_t  [`RF_WR_PORTS-1:0]  wr_req,
  output regfile_pkg::rf_word_t [`RF_RD_PORTS-1:0]  rd_dat
);

  import regfile_pkg::*;

  localparam int num_slices = `RF_DAT_W / `RF_SLICE_W;

  rd_req_t  [`RF_RD_PORTS-1:0] rd_q;
  wr_req_t  [`RF_WR_PORTS-1:0] wr_q;
  predec_t  [`RF_RD_PORTS-1:0] rd_sel;
  predec_t  [`RF_WR_PORTS-1:0] wr_sel;
  rf_word_t [`RF_RD_PORTS-1:0] raw;

  // per-slice views of the data paths
  rf_slice_t [`RF_RD_PORTS-1:0] slice_rd [num_slices];
  rf_slice_t [`RF_WR_PORTS-1:0] slice_wr [num_slices];

  // read side latches and predecoders
  for (genvar i = 0; i < `RF_RD_PORTS; i++) begin : g_rd
    port_latch #(.payload_t(rd_req_t)) u_latch (
      .clk   (clk),
      .reset (reset),
      .d     (rd_req[i]),
      .q     (rd_q[i])
    );

    addr_predecode u_predec (
      .reset (reset),
      .en    (rd_q[i].en),
      .adr   (rd_q[i].adr),
      .sel   (rd_sel[i])
    );
  end

  // write side latches and predecoders
  for (genvar i = 0; i < `RF_WR_PORTS; i++) begin : g_wr
    port_latch #(.payload_t(wr_req_t)) u_latch (
      .clk   (clk),
      .reset (reset),
      .d     (wr_req[i]),
      .q     (wr_q[i])
    );

    addr_predecode u_predec (
      .reset (reset),
      .en    (wr_q[i].en),
      .adr   (wr_q[i].adr),
      .sel   (wr_sel[i])
    );
  end

  // three slices share the same selects
  for (genvar s = 0; s < num_slices; s++) begin : g_slice
    for (genvar p = 0; p < `RF_WR_PORTS; p++) begin : g_wdat
      assign slice_wr[s][p] = wr_q[p].dat[s*`RF_SLICE_W +: `RF_SLICE_W];
    end

    for (genvar p = 0; p < `RF_RD_PORTS; p++) begin : g_rdat
      assign raw[p][s*`RF_SLICE_W +: `RF_SLICE_W] = slice_rd[s][p];
    end

    regfile_slice u_slice (
      .clk    (clk),
      .rd_sel (rd_sel),
      .rd_dat (slice_rd[s]),
      .wr_sel (wr_sel),
      .wr_dat (slice_wr[s])
    );
  end

  read_data_stage #(.latch_rd(latch_rd)) u_rd_stage (
    .clk    (clk),
    .reset  (reset),
    .raw    (raw),
    .rd_dat (rd_dat)
  );

endmodule

`default_nettype wire

/* hdl/regfile_defines.svh */
// sizes of the 4r2w register file
// the word width must be a whole multiple of the slice width
// the predecode groups assume a 6-bit address (64 words)
`ifndef REGFILE_DEFINES_SVH
`define REGFILE_DEFINES_SVH

// array geometry
`define RF_WORDS    64
`define RF_ADR_W    6
`define RF_DAT_W    72
`define RF_SLICE_W  24

// port counts
`define RF_RD_PORTS 4
`define RF_WR_PORTS 2

`endif

/* hdl/regfile_pkg.sv */
// request, predecode and word types of the 4r2w register file
// predec_t encodes a 6-bit address only
`default_nettype none

`include "regfile_defines.svh"

package regfile_pkg;

  typedef logic [`RF_ADR_W-1:0]   rf_adr_t;
  typedef logic [`RF_DAT_W-1:0]   rf_word_t;
  typedef logic [`RF_SLICE_W-1:0] rf_slice_t;

  typedef struct packed {
    logic    en;
    rf_adr_t adr;
  } rd_req_t;

  typedef struct packed {
    logic     en;
    rf_adr_t  adr;
    rf_word_t dat;
  } wr_req_t;

  // one-hot groups, index is the value of the address bits
  typedef struct packed {
    logic [1:0] c_a0;  // bit 0, carries the port enable
    logic [3:0] a12;   // bits 2:1
    logic [1:0] a3;    // bit 3
    logic [3:0] a45;   // bits 5:4
  } predec_t;

endpackage

`default_nettype wire

/* hdl/regfile_slice.sv */
// one 24-bit slice of the register file
// reads are combinational, writes land at the clock edge
// a read with no word line active returns zero
// write port 1 wins over port 0 on the same word
`default_nettype none

`include "regfile_defines.svh"

module regfile_slice (
  input  wire logic                                   clk,
  input  regfile_pkg::predec_t   [`RF_RD_PORTS-1:0]   rd_sel,
  output regfile_pkg::rf_slice_t [`RF_RD_PORTS-1:0]   rd_dat,
  input  regfile_pkg::predec_t   [`RF_WR_PORTS-1:0]   wr_sel,
  input  regfile_pkg::rf_slice_t [`RF_WR_PORTS-1:0]   wr_dat
);

  import regfile_pkg::*;

  rf_slice_t mem [`RF_WORDS];

  // AND of one bit from each group
  function automatic logic word_line(predec_t s, int unsigned w);
    logic [`RF_ADR_W-1:0] a;
    a = w[`RF_ADR_W-1:0];
    return s.c_a0[a[0]] & s.a12[a[2:1]] & s.a3[a[3]] & s.a45[a[5:4]];
  endfunction

  // read ports, OR of the selected entries
  always_comb begin
    for (int p = 0; p < `RF_RD_PORTS; p++) begin
      rd_dat[p] = '0;
      for (int w = 0; w < `RF_WORDS; w++) begin
        if (word_line(rd_sel[p], w)) begin
          rd_dat[p] = rd_dat[p] | mem[w];
        end
      end
    end
  end

  // port order matters, the later port overrides
  always_ff @(posedge clk) begin
    for (int p = 0; p < `RF_WR_PORTS; p++) begin
      for (int w = 0; w < `RF_WORDS; w++) begin
        if (word_line(wr_sel[p], w)) begin
          mem[w] <= wr_dat[p];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* regfile_4r2w.f */
+incdir+hdl
hdl/regfile_pkg.sv
hdl/port_latch.sv
hdl/addr_predecode.sv
hdl/regfile_slice.sv
hdl/read_data_stage.sv
hdl/regfile_4r2w.sv
verif/tb_clock_gen.sv
verif/regfile_4r2w_sva.sv
verif/regfile_4r2w_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the register file testbench with Verilator
verilator --binary --assert --timing --top-module regfile_4r2w_tb \
  -f regfile_4r2w.f -o sim_regfile || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_regfile +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "Verification passed" && echo "run passed" || { echo "run failed"; exit 1; }

/* verif/regfile_4r2w_sva.sv */
// concurrent checks on the register file read data
// assumes latch_rd = 1, so a read shows up 2 cycles after sampling
`default_nettype none

`include "regfile_defines.svh"

module regfile_4r2w_sva (
  input wire logic                                 clk,
  input wire logic                                 reset,
  input regfile_pkg::rd_req_t  [`RF_RD_PORTS-1:0]  rd_req,
  input regfile_pkg::rf_word_t [`RF_RD_PORTS-1:0]  rd_dat
);

  logic [`RF_RD_PORTS-1:0] en_vec;
  logic [`RF_RD_PORTS-1:0] nz_vec;
  int reset_fails = 0;
  int idle_fails = 0;
  int x_fails = 0;
  int fail_count;

  for (genvar i = 0; i < `RF_RD_PORTS; i++) begin : g_port
    assign en_vec[i] = rd_req[i].en;
    assign nz_vec[i] = |rd_dat[i];
  end

  always_comb fail_count = reset_fails + idle_fails + x_fails;

  // output register clears under reset
  a_reset_zero: assert property (@(posedge clk) reset |=> rd_dat == '0)
    else begin
      $error("rd_dat not zero the cycle after reset");
      reset_fails++;
    end

  // a port whose request en was low two edges ago must read zero
  a_idle_zero: assert property (@(posedge clk) disable iff (reset)
      (nz_vec & ~$past(en_vec, 2)) == '0)
    else begin
      $error("disabled read port returned nonzero data");
      idle_fails++;
    end

  a_no_x: assert property (@(posedge clk) disable iff (reset) !$isunknown(rd_dat))
    else begin
      $error("rd_dat unknown after reset");
      x_fails++;
    end

endmodule

bind regfile_4r2w regfile_4r2w_sva u_sva (
  .clk    (clk),
  .reset  (reset),
  .rd_req (rd_req),
  .rd_dat (rd_dat)
);

`default_nettype wire

/* verif/regfile_4r2w_tb.sv */
// testbench for the 4r2w register file with latch_rd = 1
// one table row is driven per clock, its reads are checked 2 cycles later
// expected words come from a shadow array built along with the table
`default_nettype none

`include "regfile_defines.svh"

module regfile_4r2w_tb;

  import regfile_pkg::*;

  localparam int max_rows = 64;

  typedef struct packed {
    rd_req_t  [`RF_RD_PORTS-1:0] rd;
    wr_req_t  [`RF_WR_PORTS-1:0] wr;
    rf_word_t [`RF_RD_PORTS-1:0] exp;
    int unsigned                 test;
  } row_t;

  logic clk;
  logic reset;
  rd_req_t  [`RF_RD_PORTS-1:0] rd_req;
  wr_req_t  [`RF_WR_PORTS-1:0] wr_req;
  rf_word_t [`RF_RD_PORTS-1:0] rd_dat;

  row_t     rows [max_rows];
  row_t     cur;
  rf_word_t shadow [`RF_WORDS];
  int       n_rows = 0;
  int       seed = 32'hbd1e9611;
  int       errors = 0;
  int       checks = 0;
  int       test_errors [7];
  int       cycles = 0;
  int       limit = 1000;

  tb_clock_gen u_clk (.clk(clk), .reset(reset));

  regfile_4r2w #(.latch_rd(1'b1)) DUT (
    .clk    (clk),
    .reset  (reset),
    .rd_req (rd_req),
    .wr_req (wr_req),
    .rd_dat (rd_dat)
  );

  function automatic rf_word_t rand_word();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return r[`RF_DAT_W-1:0];
  endfunction

  // all ones in one slice, zero elsewhere
  function automatic rf_word_t slice_mask(int s);
    rf_word_t m;
    m = '0;
    m[s*`RF_SLICE_W +: `RF_SLICE_W] = '1;
    return m;
  endfunction

  task automatic start_row(int test);
    cur = '0;
    cur.test = test;
  endtask

  task automatic read_on(int p, int a);
    cur.rd[p].en = 1'b1;
    cur.rd[p].adr = rf_adr_t'(a);
  endtask

  task automatic write_on(int p, int a, rf_word_t d);
    cur.wr[p].en = 1'b1;
    cur.wr[p].adr = rf_adr_t'(a);
    cur.wr[p].dat = d;
  endtask

  // reads see the array before this row's writes, port 1 written last
  task automatic commit_row();
    for (int p = 0; p < `RF_RD_PORTS; p++) begin
      cur.exp[p] = cur.rd[p].en ? shadow[cur.rd[p].adr] : '0;
    end
    for (int p = 0; p < `RF_WR_PORTS; p++) begin
      if (cur.wr[p].en) begin
        shadow[cur.wr[p].adr] = cur.wr[p].dat;
      end
    end
    rows[n_rows] = cur;
    n_rows++;
  endtask

  task automatic build_table();
    rf_word_t base;
    // idle rows right after reset
    repeat (2) begin
      start_row(1);
      commit_row();
    end
    for (int i = 0; i < 32; i++) begin
      start_row(2);
      write_on(0, 2 * i, rand_word());
      write_on(1, 2 * i + 1, rand_word());
      commit_row();
    end
    for (int i = 0; i < 16; i++) begin
      start_row(2);
      for (int p = 0; p < `RF_RD_PORTS; p++) read_on(p, 4 * i + p);
      commit_row();
    end
    // read together with a write, then one cycle later
    start_row(3);
    write_on(0, 5, rand_word());
    read_on(0, 5);
    read_on(1, 5);
    commit_row();
    start_row(3);
    read_on(0, 5);
    read_on(2, 5);
    commit_row();
    // both write ports on one word
    start_row(4);
    write_on(0, 9, rand_word());
    write_on(1, 9, rand_word());
    commit_row();
    start_row(4);
    read_on(3, 9);
    commit_row();
    // ports 1 and 3 carry an address but no enable
    start_row(5);
    read_on(0, 17);
    read_on(2, 40);
    cur.rd[1].adr = 6'd17;
    cur.rd[3].adr = 6'd63;
    commit_row();
    // words differing in a single slice
    base = rand_word();
    start_row(6);
    write_on(0, 20, base);
    write_on(1, 21, base ^ slice_mask(0));
    commit_row();
    start_row(6);
    write_on(0, 22, base ^ slice_mask(1));
    write_on(1, 23, base ^ slice_mask(2));
    commit_row();
    start_row(6);
    for (int p = 0; p < `RF_RD_PORTS; p++) read_on(p, 20 + p);
    commit_row();
  endtask

  task automatic check_row(int r);
    for (int p = 0; p < `RF_RD_PORTS; p++) begin
      checks++;
      assert (rd_dat[p] === rows[r].exp[p]) else begin
        $display("error at %0t: test %0d row %0d port %0d read %h, expected %h",
                 $time, rows[r].test, r, p, rd_dat[p], rows[r].exp[p]);
        errors++;
        test_errors[rows[r].test]++;
      end
    end
    if (r == n_rows - 1 || rows[r+1].test != rows[r].test) begin
      $display("test %0d finished, %0d errors", rows[r].test, test_errors[rows[r].test]);
    end
  endtask

  initial begin
    rd_req <= '0;
    wr_req <= '0;
    foreach (test_errors[i]) test_errors[i] = 0;
    build_table();
    limit = n_rows + 20;
    @(negedge clk);
    while (reset) @(negedge clk);
    checks++;
    assert (rd_dat === '0) else begin
      $display("error at %0t: rd_dat not zero after reset", $time);
      errors++;
      test_errors[1]++;
    end
    for (int i = 0; i < n_rows + 2; i++) begin
      @(posedge clk);
      rd_req <= (i < n_rows) ? rows[i].rd : '0;
      wr_req <= (i < n_rows) ? rows[i].wr : '0;
      @(negedge clk);
      if (i >= 2) check_row(i - 2);
    end
    $display("summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, DUT.u_sva.fail_count);
    if (errors == 0 && DUT.u_sva.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// clock and reset for the testbench
// period 100, reset high through the first 3 rising edges
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire
